// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the rename_core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module rename_core_tb \
    -o rename_core_sim

output=$(./obj_dir/rename_core_sim)
echo "$output"

if grep -q "Test completed successfully" <<< "$output"; then
    exit 0
fi
exit 1

// File: src.f
verilog/rv32i_types.sv
verilog/dispatch_if.sv
verilog/circular_queue.sv
verilog/rename_map.sv
verilog/commit_unit.sv
verilog/rename_core.sv
tests/rename_core_asserts.sv
tests/rename_core_tb.sv

// File: tests/rename_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// checks the DUT outputs against the reference models kept in the testbench.
module rename_core_asserts (
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              dispatch_valid,
    input wire logic              dispatch_ready,
    input rv32i_types::rob_idx_t  dispatch_rob_idx,
    input rv32i_types::phys_reg_t dispatch_pd0,
    input rv32i_types::phys_reg_t dispatch_pd1,
    input wire logic              commit_valid,
    input rv32i_types::arch_reg_t commit_rd0,
    input rv32i_types::arch_reg_t commit_rd1,
    input rv32i_types::phys_reg_t commit_pd0,
    input rv32i_types::phys_reg_t commit_pd1
);
    import rv32i_types::*;

    logic accepted;

    assign accepted = dispatch_valid && dispatch_ready;

    ready_matches: assert property (@(posedge clk) disable iff (rst)
        dispatch_ready == rename_core_tb.exp_ready)
    else begin
        rename_core_tb.errors++;
        $error("ERROR t=%0t dispatch_ready expected %0b actual %0b", $time,
            $sampled(rename_core_tb.exp_ready), $sampled(dispatch_ready));
    end

    rob_idx_matches: assert property (@(posedge clk) disable iff (rst)
        accepted |-> dispatch_rob_idx == rename_core_tb.exp_rob_idx)
    else begin
        rename_core_tb.errors++;
        $error("ERROR t=%0t dispatch_rob_idx expected %0d actual %0d", $time,
            $sampled(rename_core_tb.exp_rob_idx), $sampled(dispatch_rob_idx));
    end

    // new destinations come from the free list in FIFO order.
    pd_match: assert property (@(posedge clk) disable iff (rst)
        accepted |-> dispatch_pd0 == rename_core_tb.exp_pd0
                  && dispatch_pd1 == rename_core_tb.exp_pd1)
    else begin
        rename_core_tb.errors++;
        $error("ERROR t=%0t dispatch_pd0/pd1 expected %0d/%0d actual %0d/%0d", $time,
            $sampled(rename_core_tb.exp_pd0), $sampled(rename_core_tb.exp_pd1),
            $sampled(dispatch_pd0), $sampled(dispatch_pd1));
    end

    commit_valid_matches: assert property (@(posedge clk) disable iff (rst)
        commit_valid == rename_core_tb.exp_commit_valid)
    else begin
        rename_core_tb.errors++;
        $error("ERROR t=%0t commit_valid expected %0b actual %0b", $time,
            $sampled(rename_core_tb.exp_commit_valid), $sampled(commit_valid));
    end

    commit_rd_match: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_rd0 == rename_core_tb.exp_commit_rd0
                      && commit_rd1 == rename_core_tb.exp_commit_rd1)
    else begin
        rename_core_tb.errors++;
        $error("ERROR t=%0t commit_rd0/rd1 expected %0d/%0d actual %0d/%0d", $time,
            $sampled(rename_core_tb.exp_commit_rd0), $sampled(rename_core_tb.exp_commit_rd1),
            $sampled(commit_rd0), $sampled(commit_rd1));
    end

    commit_pd_match: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_pd0 == rename_core_tb.exp_commit_pd0
                      && commit_pd1 == rename_core_tb.exp_commit_pd1)
    else begin
        rename_core_tb.errors++;
        $error("ERROR t=%0t commit_pd0/pd1 expected %0d/%0d actual %0d/%0d", $time,
            $sampled(rename_core_tb.exp_commit_pd0), $sampled(rename_core_tb.exp_commit_pd1),
            $sampled(commit_pd0), $sampled(commit_pd1));
    end

endmodule : rename_core_asserts

`default_nettype wire

// File: tests/rename_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb;
    import rv32i_types::*;

    localparam int MAX_CYCLES = 2000;

    logic      clk = 1'b0;
    logic      rst;
    logic      dispatch_valid;
    arch_reg_t dispatch_rd0;
    arch_reg_t dispatch_rd1;
    logic      complete_valid0;
    logic      complete_valid1;
    rob_idx_t  complete_idx0;
    rob_idx_t  complete_idx1;
    logic      dispatch_ready;
    rob_idx_t  dispatch_rob_idx;
    phys_reg_t dispatch_pd0;
    phys_reg_t dispatch_pd1;
    logic      commit_valid;
    arch_reg_t commit_rd0;
    arch_reg_t commit_rd1;
    phys_reg_t commit_pd0;
    phys_reg_t commit_pd1;

    int errors = 0;
    int cycles = 0;
    logic complete_en;

    // the bound assertions compare the DUT outputs with these expected values.
    logic      exp_ready;
    rob_idx_t  exp_rob_idx;
    phys_reg_t exp_pd0;
    phys_reg_t exp_pd1;
    logic      exp_commit_valid;
    arch_reg_t exp_commit_rd0;
    arch_reg_t exp_commit_rd1;
    phys_reg_t exp_commit_pd0;
    phys_reg_t exp_commit_pd1;

    // reference models of the alias table, free list and ROB.
    phys_reg_t            free_model [$];
    phys_reg_t            rat_model [ARCH_REGS];
    rob_entry_t           rob_model [$];
    logic [ROB_DEPTH-1:0] done_model;
    rob_idx_t             head_model;
    rob_idx_t             tail_model;
    rob_idx_t             pending [$];
    phys_reg_t            freed0;
    phys_reg_t            freed1;

    rename_core rename_core_inst (.*);

    bind rename_core rename_core_asserts rename_core_asserts_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        rob_entry_t e0;
        rob_entry_t e1;
        logic       pop_now;
        if (rst) begin
            free_model.delete();
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_model.push_back(phys_reg_t'(i));
            end
            for (int r = 0; r < ARCH_REGS; r++) begin
                rat_model[r] = phys_reg_t'(ARCH_REGS + r);
            end
            rob_model.delete();
            pending.delete();
            done_model = '0;
            head_model = '0;
            tail_model = '0;
            exp_commit_valid = 1'b0;
        end else begin
            pop_now = rob_model.size() > 0 && done_model[tail_model]
                && done_model[tail_model + rob_idx_t'(1)];
            if (dispatch_valid && exp_ready) begin
                e0.rd = dispatch_rd0;
                e0.pd_new = free_model.pop_front();
                e0.pd_old = rat_model[dispatch_rd0];
                e1.rd = dispatch_rd1;
                e1.pd_new = free_model.pop_front();
                // a same-rd pair chains lane 1 onto lane 0's new register.
                e1.pd_old = (dispatch_rd1 == dispatch_rd0) ? e0.pd_new : rat_model[dispatch_rd1];
                rat_model[dispatch_rd0] = e0.pd_new;
                rat_model[dispatch_rd1] = e1.pd_new;
                rob_model.push_back(e0);
                rob_model.push_back(e1);
                done_model[head_model] = 1'b0;
                done_model[head_model + rob_idx_t'(1)] = 1'b0;
                pending.push_back(head_model);
                pending.push_back(head_model + rob_idx_t'(1));
                head_model = head_model + rob_idx_t'(2);
            end
            // the pair shown on commit this cycle goes back to the free list.
            if (exp_commit_valid) begin
                free_model.push_back(freed0);
                free_model.push_back(freed1);
            end
            if (pop_now) begin
                e0 = rob_model.pop_front();
                e1 = rob_model.pop_front();
                exp_commit_rd0 = e0.rd;
                exp_commit_rd1 = e1.rd;
                exp_commit_pd0 = e0.pd_new;
                exp_commit_pd1 = e1.pd_new;
                freed0 = e0.pd_old;
                freed1 = e1.pd_old;
                tail_model = tail_model + rob_idx_t'(2);
            end
            exp_commit_valid = pop_now;
            if (complete_valid0) begin
                done_model[complete_idx0] = 1'b1;
            end
            if (complete_valid1) begin
                done_model[complete_idx1] = 1'b1;
            end
        end
        exp_ready = rob_model.size() < ROB_DEPTH && free_model.size() >= 2;
        exp_rob_idx = head_model;
        exp_pd0 = (free_model.size() > 0) ? free_model[0] : '0;
        exp_pd1 = (free_model.size() > 1) ? free_model[1] : '0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // advances one clock and completes random outstanding ROB entries.
    task step();
        int k;
        @(posedge clk);
        #1;
        complete_valid0 = 1'b0;
        complete_valid1 = 1'b0;
        if (complete_en && pending.size() > 0 && $urandom_range(3, 0) != 0) begin
            k = int'($urandom_range(pending.size() - 1, 0));
            complete_idx0 = pending[k];
            pending.delete(k);
            complete_valid0 = 1'b1;
        end
        if (complete_en && pending.size() > 0 && $urandom_range(3, 0) != 0) begin
            k = int'($urandom_range(pending.size() - 1, 0));
            complete_idx1 = pending[k];
            pending.delete(k);
            complete_valid1 = 1'b1;
        end
    endtask

    task dispatch_pair(input arch_reg_t rd0, input arch_reg_t rd1);
        logic ok;
        dispatch_valid = 1'b1;
        dispatch_rd0 = rd0;
        dispatch_rd1 = rd1;
        do begin
            @(negedge clk);
            ok = dispatch_ready;
            step();
        end while (!ok);
        dispatch_valid = 1'b0;
    endtask

    task random_pair();
        arch_reg_t a;
        arch_reg_t b;
        a = arch_reg_t'($urandom_range(ARCH_REGS - 1, 0));
        b = ($urandom_range(3, 0) == 0) ? a : arch_reg_t'($urandom_range(ARCH_REGS - 1, 0));
        dispatch_pair(a, b);
    endtask

    task wait_drained();
        while (rob_model.size() > 0 || exp_commit_valid) begin
            step();
        end
    endtask

    initial begin
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_rd0 = '0;
        dispatch_rd1 = '0;
        complete_valid0 = 1'b0;
        complete_valid1 = 1'b0;
        complete_idx0 = '0;
        complete_idx1 = '0;
        complete_en = 1'b0;
        void'($urandom(32'h3e7dfcb1));
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        dispatch_pair(arch_reg_t'(5), arch_reg_t'(9));
        complete_en = 1'b1;
        dispatch_pair(arch_reg_t'(7), arch_reg_t'(7));
        dispatch_pair(arch_reg_t'(7), arch_reg_t'(2));
        // enough pairs that the free list wraps and recycles registers.
        repeat (60) begin
            random_pair();
            if ($urandom_range(3, 0) == 0) begin
                step();
            end
        end
        wait_drained();
        complete_en = 1'b0;
        repeat (8) random_pair();
        // the ROB is full now, so this pair waits until a pair retires.
        dispatch_valid = 1'b1;
        dispatch_rd0 = arch_reg_t'(3);
        dispatch_rd1 = arch_reg_t'(4);
        repeat (5) step();
        complete_en = 1'b1;
        dispatch_pair(arch_reg_t'(3), arch_reg_t'(4));
        wait_drained();
        repeat (3) step();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : rename_core_tb

`default_nettype wire

// File: verilog/circular_queue.sv
`timescale 1ns/1ps
`default_nettype none

module circular_queue #(
    parameter type                          QUEUE_TYPE = rv32i_types::phys_reg_t,
    parameter rv32i_types::initialization_t INIT_TYPE  = rv32i_types::ZERO,
    parameter int                           DEPTH      = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       push,
    input  wire logic                       pop,
    input  QUEUE_TYPE                       in [rv32i_types::SS],
    output logic                            empty,
    output logic                            full,
    output logic [$clog2(DEPTH)-1:0]        head_out,
    output logic [$clog2(DEPTH)-1:0]        tail_out,
    output QUEUE_TYPE                       out [rv32i_types::SS],
    output QUEUE_TYPE                       peek [rv32i_types::SS]
);
    import rv32i_types::*;

    localparam int IW = $clog2(DEPTH);

    QUEUE_TYPE entries [DEPTH];

    // the extra top bit flips on every wrap, so equal indices with
    // different wrap bits mean the queue is full.
    logic [IW:0]   head;
    logic [IW:0]   tail;
    logic [IW-1:0] head_lane [SS];
    logic [IW-1:0] tail_lane [SS];

    assign head_out = head[IW-1:0];
    assign tail_out = tail[IW-1:0];

    assign empty = (head == tail);
    assign full  = (head[IW-1:0] == tail[IW-1:0]) && (head[IW] != tail[IW]);

    // entry index used by each lane, wrapping around the end of the array.
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            head_lane[i] = head[IW-1:0] + IW'(i);
            tail_lane[i] = tail[IW-1:0] + IW'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
            if (INIT_TYPE == FREE_LIST) begin
                // every entry holds a valid value, so start out full.
                head <= {1'b1, {IW{1'b0}}};
                for (int i = 0; i < DEPTH; i++) begin
                    entries[i] <= QUEUE_TYPE'(i);
                end
            end else begin
                head <= '0;
                for (int i = 0; i < DEPTH; i++) begin
                    entries[i] <= '0;
                end
            end
        end else begin
            if (push) begin
                head <= head + (IW+1)'(SS);
                for (int i = 0; i < SS; i++) begin
                    entries[head_lane[i]] <= in[i];
                end
            end
            if (pop) begin
                tail <= tail + (IW+1)'(SS);
            end
        end
    end

    // popped data is held until the next pop.
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int i = 0; i < SS; i++) begin
                out[i] <= entries[tail_lane[i]];
            end
        end
    end

    // look at the oldest pair without removing it.
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            peek[i] = entries[tail_lane[i]];
        end
    end

endmodule : circular_queue

`default_nettype wire

// File: verilog/commit_unit.sv
`timescale 1ns/1ps
`default_nettype none

module commit_unit (
    input  wire logic              clk,
    input  wire logic              rst,
    dispatch_if.rob                rob,
    input  wire logic              complete_valid [rv32i_types::SS],
    input  rv32i_types::rob_idx_t  complete_idx [rv32i_types::SS],
    output logic                   commit_valid,
    output rv32i_types::arch_reg_t commit_rd [rv32i_types::SS],
    output rv32i_types::phys_reg_t commit_pd [rv32i_types::SS],
    output logic                   free_push,
    output rv32i_types::phys_reg_t free_pd [rv32i_types::SS]
);
    import rv32i_types::*;

    rob_entry_t           rob_out [SS];
    rob_idx_t             rob_tail;
    logic                 rob_empty;
    logic [ROB_DEPTH-1:0] done;
    logic                 pair_done;
    logic                 pop;

    circular_queue #(
        .QUEUE_TYPE (rob_entry_t),
        .INIT_TYPE  (ZERO),
        .DEPTH      (ROB_DEPTH)
    ) rob_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (rob.push),
        .pop      (pop),
        .in       (rob.entry),
        .empty    (rob_empty),
        .full     (rob.full),
        .head_out (rob.head),
        .tail_out (rob_tail),
        .out      (rob_out),
        .peek     ()
    );

    // a slot is cleared when it is reused, so stale flags from the
    // previous lap never let a new pair retire early.
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= '0;
        end else begin
            if (rob.push) begin
                for (int i = 0; i < SS; i++) begin
                    done[rob.head + rob_idx_t'(i)] <= 1'b0;
                end
            end
            for (int i = 0; i < SS; i++) begin
                if (complete_valid[i]) begin
                    done[complete_idx[i]] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        pair_done = 1'b1;
        for (int i = 0; i < SS; i++) begin
            pair_done = pair_done && done[rob_tail + rob_idx_t'(i)];
        end
    end

    // retire strictly in order, a whole pair at a time.
    assign pop = !rob_empty && pair_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= pop;
        end
    end

    // the queue output register holds the pair popped on the last edge.
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            commit_rd[i] = rob_out[i].rd;
            commit_pd[i] = rob_out[i].pd_new;
            free_pd[i]   = rob_out[i].pd_old;
        end
    end

    assign free_push = commit_valid;

endmodule : commit_unit

`default_nettype wire

// File: verilog/dispatch_if.sv
`timescale 1ns/1ps
`default_nettype none

// carries one renamed pair from the rename stage into the ROB.
interface dispatch_if;
    import rv32i_types::*;

    // a one-cycle strobe that writes both lanes together.
    logic       push;
    rob_entry_t entry [SS];

    // ROB status seen by the rename stage.
    logic       full;
    rob_idx_t   head;

    modport rename (
        output push,
        output entry,
        input  full,
        input  head
    );

    modport rob (
        input  push,
        input  entry,
        output full,
        output head
    );

endinterface : dispatch_if

`default_nettype wire

// File: verilog/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              dispatch_valid,
    input  rv32i_types::arch_reg_t dispatch_rd0,
    input  rv32i_types::arch_reg_t dispatch_rd1,
    input  wire logic              complete_valid0,
    input  wire logic              complete_valid1,
    input  rv32i_types::rob_idx_t  complete_idx0,
    input  rv32i_types::rob_idx_t  complete_idx1,
    output logic                   dispatch_ready,
    output rv32i_types::rob_idx_t  dispatch_rob_idx,
    output rv32i_types::phys_reg_t dispatch_pd0,
    output rv32i_types::phys_reg_t dispatch_pd1,
    output logic                   commit_valid,
    output rv32i_types::arch_reg_t commit_rd0,
    output rv32i_types::arch_reg_t commit_rd1,
    output rv32i_types::phys_reg_t commit_pd0,
    output rv32i_types::phys_reg_t commit_pd1
);
    import rv32i_types::*;

    arch_reg_t dispatch_rd [SS];
    phys_reg_t dispatch_pd [SS];
    logic      complete_valid [SS];
    rob_idx_t  complete_idx [SS];
    arch_reg_t commit_rd [SS];
    phys_reg_t commit_pd [SS];
    logic      free_push;
    phys_reg_t free_pd [SS];

    dispatch_if rob_if ();

    // lane 0 is the older instruction of each pair.
    assign dispatch_rd[0]    = dispatch_rd0;
    assign dispatch_rd[1]    = dispatch_rd1;
    assign complete_valid[0] = complete_valid0;
    assign complete_valid[1] = complete_valid1;
    assign complete_idx[0]   = complete_idx0;
    assign complete_idx[1]   = complete_idx1;

    assign dispatch_pd0     = dispatch_pd[0];
    assign dispatch_pd1     = dispatch_pd[1];
    assign dispatch_rob_idx = rob_if.head;
    assign commit_rd0       = commit_rd[0];
    assign commit_rd1       = commit_rd[1];
    assign commit_pd0       = commit_pd[0];
    assign commit_pd1       = commit_pd[1];

    rename_map rename_map_inst (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_rd    (dispatch_rd),
        .dispatch_ready (dispatch_ready),
        .dispatch_pd    (dispatch_pd),
        .free_push      (free_push),
        .free_pd        (free_pd),
        .rob            (rob_if.rename)
    );

    commit_unit commit_unit_inst (
        .clk            (clk),
        .rst            (rst),
        .rob            (rob_if.rob),
        .complete_valid (complete_valid),
        .complete_idx   (complete_idx),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_pd      (commit_pd),
        .free_push      (free_push),
        .free_pd        (free_pd)
    );

endmodule : rename_core

`default_nettype wire

// File: verilog/rename_map.sv
`timescale 1ns/1ps
`default_nettype none

module rename_map (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              dispatch_valid,
    input  rv32i_types::arch_reg_t dispatch_rd [rv32i_types::SS],
    output logic                   dispatch_ready,
    output rv32i_types::phys_reg_t dispatch_pd [rv32i_types::SS],
    input  wire logic              free_push,
    input  rv32i_types::phys_reg_t free_pd [rv32i_types::SS],
    dispatch_if.rename             rob
);
    import rv32i_types::*;

    // registers not held in the free list at reset belong to the table.
    localparam int MAP_BASE = PHYS_REGS - ARCH_REGS;

    phys_reg_t  rat [ARCH_REGS];
    phys_reg_t  free_peek [SS];
    phys_reg_t  pd_old [SS];
    rob_entry_t new_entry [SS];
    logic       free_empty;
    logic       accept;

    circular_queue #(
        .QUEUE_TYPE (phys_reg_t),
        .INIT_TYPE  (FREE_LIST),
        .DEPTH      (FREE_DEPTH)
    ) free_list (
        .clk      (clk),
        .rst      (rst),
        .push     (free_push),
        .pop      (accept),
        .in       (free_pd),
        .empty    (free_empty),
        .full     (),
        .head_out (),
        .tail_out (),
        .out      (),
        .peek     (free_peek)
    );

    assign dispatch_ready = !rob.full && !free_empty;
    assign accept         = dispatch_valid && dispatch_ready;

    // the two oldest free registers become the new destinations.
    assign dispatch_pd = free_peek;

    // an older lane of the same pair that writes the same rd overrides the
    // table, since its rename takes effect before the younger lane.
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            pd_old[i] = rat[dispatch_rd[i]];
            for (int j = 0; j < i; j++) begin
                if (dispatch_rd[j] == dispatch_rd[i]) begin
                    pd_old[i] = free_peek[j];
                end
            end
            new_entry[i].rd     = dispatch_rd[i];
            new_entry[i].pd_new = free_peek[i];
            new_entry[i].pd_old = pd_old[i];
        end
    end

    assign rob.push  = accept;
    assign rob.entry = new_entry;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                rat[r] <= phys_reg_t'(MAP_BASE + r);
            end
        end else if (accept) begin
            // later lanes are written last, so the youngest mapping wins.
            for (int i = 0; i < SS; i++) begin
                rat[dispatch_rd[i]] <= free_peek[i];
            end
        end
    end

endmodule : rename_map

`default_nettype wire

// File: verilog/rv32i_types.sv
`default_nettype none

package rv32i_types;

    // machine width.
    localparam int SS = 2;

    // register file sizes.
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // queue depths, counted in single entries and not in pairs.
    localparam int FREE_DEPTH = 32;
    localparam int ROB_DEPTH  = 16;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

    // one renamed destination as it sits in the reorder buffer.
    // pd_old is the mapping that rd had before this instruction and
    // goes back to the free list once the instruction retires.
    typedef struct packed {
        arch_reg_t rd;
        phys_reg_t pd_new;
        phys_reg_t pd_old;
    } rob_entry_t;

    // reset contents of a circular queue.
    // ZERO clears every entry, FREE_LIST loads entry i with i and
    // starts the queue full.
    typedef enum logic {
        ZERO,
        FREE_LIST
    } initialization_t;

endpackage : rv32i_types

`default_nettype wire
